/* mem_nr1w.f */
rtl/mem_nr1w_pkg.sv
rtl/addr_split.sv
rtl/bank_sram.sv
rtl/read_return.sv
rtl/core_nr1w_dup.sv
rtl/mem_nr1w_top.sv
verification/tb_mem_nr1w.sv

/* rtl/addr_split.sv */
module addr_split (
  input  logic [mem_nr1w_pkg::BITADDR-1:0] addr,
  output logic [mem_nr1w_pkg::BITVBNK-1:0] bank,
  output logic [mem_nr1w_pkg::BITVROW-1:0] row
);

  import mem_nr1w_pkg::*;

  logic [31:0] bank_full;
  logic [31:0] row_full;

  // constant divisor so the bank count need not be a power of two
  always_comb begin
    bank_full = 32'(addr) % NUMVBNK;
    row_full  = 32'(addr) / NUMVBNK;
  end

  assign bank = bank_full[BITVBNK-1:0];
  assign row  = row_full[BITVROW-1:0];

  // in-range address must land on an existing row
  always_comb begin
    if (32'(addr) < NUMADDR) begin
      assert (row_full < NUMVROW)
        else $error("addr_split: row %0d out of range for addr %0d", row_full, addr);
    end
  end

endmodule

/* rtl/bank_sram.sv */
module bank_sram #(
  parameter int SRAM_DELAY = 2
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  mem_nr1w_pkg::bank_cmd_t         cmd,
  output logic [mem_nr1w_pkg::WIDTH-1:0]  dout
);

  import mem_nr1w_pkg::*;

  logic [WIDTH-1:0] mem [NUMVROW];
  logic [WIDTH-1:0] rd_pipe [SRAM_DELAY];

  // read samples the row before this cycle's write lands
  always_ff @(posedge clk) begin
    if (cmd.write) begin
      mem[cmd.wr_row] <= (mem[cmd.wr_row] & ~cmd.bw) | (cmd.din & cmd.bw);
    end
    if (cmd.read) begin
      rd_pipe[0] <= mem[cmd.rd_row];
    end
    for (int i = 1; i < SRAM_DELAY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign dout = rd_pipe[SRAM_DELAY-1];

  // rows come from the core address split
  a_wr_row_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    cmd.write |-> (32'(cmd.wr_row) < NUMVROW)
  ) else $error("bank_sram: write row %0d out of range", cmd.wr_row);

  a_rd_row_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    cmd.read |-> (32'(cmd.rd_row) < NUMVROW)
  ) else $error("bank_sram: read row %0d out of range", cmd.rd_row);

endmodule

/* rtl/core_nr1w_dup.sv */
module core_nr1w_dup #(
  parameter int NUMRDPT = 2,
  parameter int FLOPIN  = 1
) (
  input  logic                                                          clk,
  input  logic                                                          rst_n,
  input  mem_nr1w_pkg::wr_req_t                                         wr_req,
  input  mem_nr1w_pkg::rd_req_t [NUMRDPT-1:0]                           rd_req,
  output mem_nr1w_pkg::bank_cmd_t [NUMRDPT-1:0][mem_nr1w_pkg::NUMVBNK-1:0] bank_cmd,
  output mem_nr1w_pkg::rd_tag_t [NUMRDPT-1:0]                           rd_tag
);

  import mem_nr1w_pkg::*;

  wr_req_t                 wr_s;
  rd_req_t [NUMRDPT-1:0]   rd_s;
  logic [BITVBNK-1:0]      wr_bank;
  logic [BITVROW-1:0]      wr_row;
  logic [NUMRDPT-1:0][BITVBNK-1:0] rd_bank;
  logic [NUMRDPT-1:0][BITVROW-1:0] rd_row;

  if (FLOPIN != 0) begin : g_flopin
    logic                  wr_vld_q;
    logic [NUMRDPT-1:0]    rd_vld_q;
    wr_req_t               wr_q;
    rd_req_t [NUMRDPT-1:0] rd_q;

    // input register stage
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        wr_vld_q <= 1'b0;
        rd_vld_q <= '0;
      end else begin
        wr_vld_q <= wr_req.write;
        for (int p = 0; p < NUMRDPT; p++) begin
          rd_vld_q[p] <= rd_req[p].read;
        end
      end
    end

    always_ff @(posedge clk) begin
      wr_q <= wr_req;
      rd_q <= rd_req;
    end

    always_comb begin
      wr_s       = wr_q;
      wr_s.write = wr_vld_q;
      rd_s       = rd_q;
      for (int p = 0; p < NUMRDPT; p++) begin
        rd_s[p].read = rd_vld_q[p];
      end
    end
  end else begin : g_no_flopin
    assign wr_s = wr_req;
    assign rd_s = rd_req;
  end

  addr_split u_wr_split (.addr(wr_s.addr), .bank(wr_bank), .row(wr_row));

  for (genvar p = 0; p < NUMRDPT; p++) begin : g_rd_split
    addr_split u_rd_split (.addr(rd_s[p].addr), .bank(rd_bank[p]), .row(rd_row[p]));

    a_rd_addr_range: assert property (
      @(posedge clk) disable iff (!rst_n)
      rd_s[p].read |-> (32'(rd_s[p].addr) < NUMADDR)
    ) else $error("core: read port %0d address %0d out of range", p, rd_s[p].addr);
  end

  // write hits one bank in every copy while a read fires all banks of its copy
  always_comb begin
    for (int c = 0; c < NUMRDPT; c++) begin
      for (int b = 0; b < NUMVBNK; b++) begin
        bank_cmd[c][b].write  = wr_s.write && (wr_bank == BITVBNK'(b));
        bank_cmd[c][b].wr_row = wr_row;
        bank_cmd[c][b].bw     = wr_s.bw;
        bank_cmd[c][b].din    = wr_s.din;
        bank_cmd[c][b].read   = rd_s[c].read;
        bank_cmd[c][b].rd_row = rd_row[c];
      end
      rd_tag[c].read = rd_s[c].read;
      rd_tag[c].bank = rd_bank[c];
    end
  end

  a_wr_addr_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_s.write |-> (32'(wr_s.addr) < NUMADDR)
  ) else $error("core: write address %0d out of range", wr_s.addr);

endmodule

/* rtl/mem_nr1w_pkg.sv */
package mem_nr1w_pkg;

  // memory geometry
  localparam int WIDTH   = 32;
  localparam int NUMADDR = 48;
  localparam int BITADDR = 6;
  localparam int NUMVBNK = 3;
  localparam int BITVBNK = 2;
  localparam int NUMVROW = 16;
  localparam int BITVROW = 4;

  typedef struct packed {
    logic               write;
    logic [BITADDR-1:0] addr;
    logic [WIDTH-1:0]   bw;
    logic [WIDTH-1:0]   din;
  } wr_req_t;

  typedef struct packed {
    logic               read;
    logic [BITADDR-1:0] addr;
  } rd_req_t;

  typedef struct packed {
    logic               write;
    logic [BITVROW-1:0] wr_row;
    logic [WIDTH-1:0]   bw;
    logic [WIDTH-1:0]   din;
    logic               read;
    logic [BITVROW-1:0] rd_row;
  } bank_cmd_t;

  // carried alongside the sram read latency
  typedef struct packed {
    logic               read;
    logic [BITVBNK-1:0] bank;
  } rd_tag_t;

endpackage

/* rtl/mem_nr1w_top.sv */
module mem_nr1w_top #(
  parameter int NUMRDPT    = 2,
  parameter int SRAM_DELAY = 2,
  parameter int FLOPIN     = 1,
  parameter int FLOPOUT    = 1
) (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        flopout_en,
  input  mem_nr1w_pkg::wr_req_t                       wr_req,
  input  mem_nr1w_pkg::rd_req_t [NUMRDPT-1:0]         rd_req,
  output logic [NUMRDPT-1:0]                          rd_vld,
  output logic [NUMRDPT-1:0][mem_nr1w_pkg::WIDTH-1:0] rd_data
);

  import mem_nr1w_pkg::*;

  bank_cmd_t [NUMRDPT-1:0][NUMVBNK-1:0]    bank_cmd;
  rd_tag_t [NUMRDPT-1:0]                   rd_tag;
  logic [NUMRDPT-1:0][NUMVBNK-1:0][WIDTH-1:0] bank_dout;

  core_nr1w_dup #(
    .NUMRDPT (NUMRDPT),
    .FLOPIN  (FLOPIN)
  ) u_core (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_req   (wr_req),
    .rd_req   (rd_req),
    .bank_cmd (bank_cmd),
    .rd_tag   (rd_tag)
  );

  // one full copy of the storage per read port
  for (genvar c = 0; c < NUMRDPT; c++) begin : g_copy
    for (genvar b = 0; b < NUMVBNK; b++) begin : g_bank
      bank_sram #(.SRAM_DELAY(SRAM_DELAY)) u_bank (
        .clk   (clk),
        .rst_n (rst_n),
        .cmd   (bank_cmd[c][b]),
        .dout  (bank_dout[c][b])
      );
    end
  end

  for (genvar p = 0; p < NUMRDPT; p++) begin : g_port
    read_return #(
      .SRAM_DELAY (SRAM_DELAY),
      .FLOPOUT    (FLOPOUT)
    ) u_ret (
      .clk        (clk),
      .rst_n      (rst_n),
      .flopout_en (flopout_en),
      .tag        (rd_tag[p]),
      .bank_dout  (bank_dout[p]),
      .rd_vld     (rd_vld[p]),
      .rd_data    (rd_data[p])
    );
  end

endmodule

/* rtl/read_return.sv */
module read_return #(
  parameter int SRAM_DELAY = 2,
  parameter int FLOPOUT    = 1
) (
  input  logic                                                     clk,
  input  logic                                                     rst_n,
  input  logic                                                     flopout_en,
  input  mem_nr1w_pkg::rd_tag_t                                    tag,
  input  logic [mem_nr1w_pkg::NUMVBNK-1:0][mem_nr1w_pkg::WIDTH-1:0] bank_dout,
  output logic                                                     rd_vld,
  output logic [mem_nr1w_pkg::WIDTH-1:0]                           rd_data
);

  import mem_nr1w_pkg::*;

  logic [SRAM_DELAY-1:0] vld_pipe;
  logic [BITVBNK-1:0]    bank_pipe [SRAM_DELAY];
  logic                  sel_vld;
  logic [BITVBNK-1:0]    sel_bank;
  logic [WIDTH-1:0]      sel_data;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe[0] <= tag.read;
      for (int i = 1; i < SRAM_DELAY; i++) begin
        vld_pipe[i] <= vld_pipe[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    bank_pipe[0] <= tag.bank;
    for (int i = 1; i < SRAM_DELAY; i++) begin
      bank_pipe[i] <= bank_pipe[i-1];
    end
  end

  assign sel_vld  = vld_pipe[SRAM_DELAY-1];
  assign sel_bank = bank_pipe[SRAM_DELAY-1];
  // pick the word of the bank that was addressed
  assign sel_data = bank_dout[sel_bank];

  if (FLOPOUT != 0) begin : g_flopout
    logic             vld_q;
    logic [WIDTH-1:0] data_q;

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        vld_q <= 1'b0;
      end else begin
        vld_q <= sel_vld;
      end
    end

    always_ff @(posedge clk) begin
      data_q <= sel_data;
    end

    // flopout_en skips the output stage
    assign rd_vld  = flopout_en ? sel_vld : vld_q;
    assign rd_data = flopout_en ? sel_data : data_q;
  end else begin : g_no_flopout
    assign rd_vld  = sel_vld;
    assign rd_data = sel_data;
  end

  a_bank_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    sel_vld |-> (32'(sel_bank) < NUMVBNK)
  ) else $error("read_return: returned bank %0d out of range", sel_bank);

endmodule

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_mem_nr1w --Mdir obj_dir -o tb_mem_nr1w \
  -f mem_nr1w.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_mem_nr1w 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "Simulation PASSED"; then
  exit 0
fi

echo "pass line not found in simulator output"
exit 1

/* verification/mem_nr1w_stimulus.txt */
// mode flopout_en wr wr_addr bw din rd0 rd0_addr rd1 rd1_addr exp0 exp1
// one vector per clock, all hex, mode is the test number
1 0 0 00 00000000 00000000 0 00 0 00 00000000 00000000
1 0 0 00 00000000 00000000 0 00 0 00 00000000 00000000
1 0 0 00 00000000 00000000 0 00 0 00 00000000 00000000
2 0 1 00 ffffffff 11111111 0 00 0 00 00000000 00000000
2 0 1 04 ffffffff 22222222 0 00 0 00 00000000 00000000
2 0 1 08 ffffffff 33333333 0 00 0 00 00000000 00000000
2 0 1 1d ffffffff a5a5a5a5 0 00 0 00 00000000 00000000
2 0 1 2f ffffffff deadbeef 0 00 0 00 00000000 00000000
2 0 1 16 ffffffff 0badf00d 0 00 0 00 00000000 00000000
2 0 1 21 ffffffff 12345678 0 00 0 00 00000000 00000000
2 0 0 00 00000000 00000000 1 00 1 00 11111111 11111111
2 0 0 00 00000000 00000000 1 04 1 04 22222222 22222222
2 0 0 00 00000000 00000000 1 08 1 08 33333333 33333333
2 0 0 00 00000000 00000000 1 1d 1 1d a5a5a5a5 a5a5a5a5
2 0 0 00 00000000 00000000 1 2f 1 2f deadbeef deadbeef
2 0 0 00 00000000 00000000 1 16 1 16 0badf00d 0badf00d
2 0 0 00 00000000 00000000 1 21 1 21 12345678 12345678
3 0 1 04 0000ffff 5555aaaa 0 00 0 00 00000000 00000000
3 0 1 2f ff00ff00 12345678 0 00 0 00 00000000 00000000
3 0 0 00 00000000 00000000 1 04 1 04 2222aaaa 2222aaaa
3 0 0 00 00000000 00000000 1 2f 1 2f 12ad56ef 12ad56ef
4 0 0 00 00000000 00000000 1 00 1 08 11111111 33333333
4 0 0 00 00000000 00000000 1 1d 1 16 a5a5a5a5 0badf00d
4 0 0 00 00000000 00000000 1 21 1 04 12345678 2222aaaa
4 0 0 00 00000000 00000000 1 2f 1 00 12ad56ef 11111111
4 0 0 00 00000000 00000000 1 16 1 21 0badf00d 12345678
5 0 1 08 ffffffff 77777777 1 08 1 08 33333333 33333333
5 0 0 00 00000000 00000000 1 08 1 08 77777777 77777777
5 0 1 1d ffffffff 0f0f0f0f 1 1d 1 2f a5a5a5a5 12ad56ef
5 0 0 00 00000000 00000000 0 00 1 1d 00000000 0f0f0f0f
5 0 0 00 00000000 00000000 0 00 0 00 00000000 00000000
5 0 0 00 00000000 00000000 0 00 0 00 00000000 00000000
5 0 0 00 00000000 00000000 0 00 0 00 00000000 00000000
5 0 0 00 00000000 00000000 0 00 0 00 00000000 00000000
6 1 0 00 00000000 00000000 0 00 0 00 00000000 00000000
6 1 0 00 00000000 00000000 1 00 1 08 11111111 77777777
6 1 0 00 00000000 00000000 1 04 1 2f 2222aaaa 12ad56ef
6 1 0 00 00000000 00000000 1 1d 1 21 0f0f0f0f 12345678
6 1 0 00 00000000 00000000 0 00 0 00 00000000 00000000

/* verification/tb_mem_nr1w.sv */
module tb_mem_nr1w;
  timeunit 1ns;
  timeprecision 1ps;

  import mem_nr1w_pkg::*;

  localparam int NUMRDPT    = 2;
  localparam int SRAM_DELAY = 2;
  localparam int FLOPIN     = 1;
  localparam int FLOPOUT    = 1;
  localparam int RST_CYCLES = 10;
  localparam int MAX_VEC    = 64;
  localparam int FIELDS     = 12;
  localparam int LAT_MAX    = FLOPIN + SRAM_DELAY + FLOPOUT;

  // an outstanding read and the cycle its rd_vld is due
  typedef struct packed {
    int               due;
    logic [3:0]       mode;
    logic [WIDTH-1:0] data;
  } pend_t;

  logic                          clk;
  logic                          rst_n;
  logic                          flopout_en;
  wr_req_t                       wr_req;
  rd_req_t [NUMRDPT-1:0]         rd_req;
  logic [NUMRDPT-1:0]            rd_vld;
  logic [NUMRDPT-1:0][WIDTH-1:0] rd_data;

  logic [31:0] vec_words [MAX_VEC*FIELDS];
  pend_t       pend_q [NUMRDPT][$];
  int          num_vec;
  int          cycle_cnt = 0;
  int          cycle_limit;

  mem_nr1w_top UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .flopout_en (flopout_en),
    .wr_req     (wr_req),
    .rd_req     (rd_req),
    .rd_vld     (rd_vld),
    .rd_data    (rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  function automatic string test_name(logic [3:0] mode);
    case (mode)
      4'd1: return "idle_after_reset";
      4'd2: return "write_readback";
      4'd3: return "masked_write";
      4'd4: return "back_to_back_reads";
      4'd5: return "same_addr_rw";
      4'd6: return "flopout_bypass";
      default: return "unknown";
    endcase
  endfunction

  task automatic stop_run(string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "run stopped at cycle %0d", cycle_cnt);
  endtask

  task automatic check_value(string name, logic [WIDTH-1:0] expected,
                             logic [WIDTH-1:0] actual);
    if (actual !== expected) begin
      stop_run($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_port(int p);
    pend_t head;
    if (pend_q[p].size() == 0) begin
      if (rd_vld[p]) begin
        stop_run($sformatf("port %0d raised rd_vld with no read outstanding", p));
      end
    end else begin
      head = pend_q[p][0];
      if (rd_vld[p]) begin
        if (head.due != cycle_cnt) begin
          stop_run($sformatf("port %0d rd_vld came at cycle %0d but was due at cycle %0d",
                             p, cycle_cnt, head.due));
        end
        check_value($sformatf("%s port%0d", test_name(head.mode), p), head.data, rd_data[p]);
        void'(pend_q[p].pop_front());
      end else if (head.due <= cycle_cnt) begin
        stop_run($sformatf("port %0d rd_vld missing, read was due at cycle %0d", p, head.due));
      end
    end
  endtask

  // outputs are sampled half a cycle after the edge that set them
  always @(negedge clk) begin
    if (cycle_cnt >= cycle_limit) begin
      stop_run($sformatf("timeout after %0d cycles with reads still outstanding", cycle_cnt));
    end
    if (rst_n) begin
      for (int p = 0; p < NUMRDPT; p++) begin
        check_port(p);
      end
    end
  end

  initial begin
    logic [31:0] f [FIELDS];
    pend_t       entry;
    int          lat;

    rst_n      <= 1'b0;
    flopout_en <= 1'b0;
    wr_req     <= '0;
    rd_req     <= '0;

    for (int i = 0; i < MAX_VEC * FIELDS; i++) begin
      vec_words[i] = 32'd0;
    end
    $readmemh("verification/mem_nr1w_stimulus.txt", vec_words);

    // mode 0 marks the end of the vectors
    num_vec = 0;
    while (num_vec < MAX_VEC && vec_words[num_vec*FIELDS] != 32'd0) begin
      num_vec++;
    end
    if (num_vec == 0) begin
      stop_run("no stimulus vectors were loaded");
    end
    cycle_limit = RST_CYCLES + num_vec + LAT_MAX + 20;

    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < num_vec; i++) begin
      @(posedge clk);
      for (int k = 0; k < FIELDS; k++) begin
        f[k] = vec_words[i*FIELDS + k];
      end
      lat = FLOPIN + SRAM_DELAY + (f[1][0] ? 0 : FLOPOUT);
      flopout_en   <= f[1][0];
      wr_req.write <= f[2][0];
      wr_req.addr  <= f[3][BITADDR-1:0];
      wr_req.bw    <= f[4];
      wr_req.din   <= f[5];
      for (int p = 0; p < NUMRDPT; p++) begin
        rd_req[p].read <= f[6 + 2*p][0];
        rd_req[p].addr <= f[7 + 2*p][BITADDR-1:0];
        if (f[6 + 2*p][0]) begin
          entry.due  = cycle_cnt + 1 + lat;
          entry.mode = f[0][3:0];
          entry.data = f[10 + p];
          pend_q[p].push_back(entry);
        end
      end
    end

    @(posedge clk);
    wr_req <= '0;
    rd_req <= '0;

    while (pend_q[0].size() != 0 || pend_q[1].size() != 0) begin
      @(posedge clk);
    end
    // a few quiet cycles to catch a stray rd_vld
    repeat (4) @(posedge clk);
    $display("Simulation PASSED");
    $finish;
  end

endmodule
